//--- all.f
core_pkg.sv
core_regs.sv
fetch_stage.sv
decoder.sv
regfile.sv
execute_stage.sv
core_top.sv
tb_core_assert.sv
tb_core.sv

//--- core_golden.txt
// golden image for tb_core, hex words loaded with $readmemh
// step lines: kind offset wdata rdata pslverr
// kinds: 0 write, 1 read, 2 read of the retired count, 3 run to halt, 4 reset
// record lines: pc inst rd rd_data rs1_data rs2_data trap halt
@000
// second segment, booted from the reset address, traps on a funct7 of 1
12300093 02108133 00100193
@010
// first segment at 0x40, dependent ALU and LUI chain ending in ebreak
123450b7 67808093 fff00113 002081b3
40118233 40425293 0002a333 005033b3
0060c433 00540013 007064b3 01f49513
002575b3 00100073
@040
// number of steps, number of records, number of program words
00000016 00000010 00000011
@048
1 0 00000000 00000000 0
1 4 00000000 00000000 0
1 8 00000000 00000000 0
1 c 00000000 00000000 0
0 8 00000001 00000000 1
1 8 00000000 00000000 0
1 3 00000000 00000000 1
0 4 00000040 00000000 0
1 4 00000000 00000040 0
0 0 00000001 00000000 0
3 0 0000000e 00000000 0
1 8 00000000 00000001 0
2 c 00000000 00000000 0
0 c 00000000 00000000 1
2 c 00000000 00000000 0
4 0 00000000 00000000 0
1 4 00000000 00000000 0
1 0 00000000 00000000 0
0 0 00000001 00000000 0
3 0 00000010 00000000 0
1 8 00000000 00000001 0
2 c 00000000 00000000 0
@100
00000040 123450b7 00000001 12345000 00000000 00000000 0 0
00000044 67808093 00000001 12345678 12345000 00000000 0 0
00000048 fff00113 00000002 ffffffff 00000000 00000000 0 0
0000004c 002081b3 00000003 12345677 12345678 ffffffff 0 0
00000050 40118233 00000004 ffffffff 12345677 12345678 0 0
00000054 40425293 00000005 ffffffff ffffffff 00000000 0 0
00000058 0002a333 00000006 00000001 ffffffff 00000000 0 0
0000005c 005033b3 00000007 00000001 00000000 ffffffff 0 0
00000060 0060c433 00000008 12345679 12345678 00000001 0 0
00000064 00540013 00000000 1234567e 12345679 00000000 0 0
00000068 007064b3 00000009 00000001 00000000 00000001 0 0
0000006c 01f49513 0000000a 80000000 00000001 00000000 0 0
00000070 002575b3 0000000b 80000000 80000000 ffffffff 0 0
00000074 00100073 00000000 00000000 00000000 00000000 0 1
00000000 12300093 00000001 00000123 00000000 00000000 0 0
00000004 02108133 00000000 00000246 00000123 00000123 1 1

//--- core_pkg.sv
`default_nettype none

package core_pkg;

    // machine word width and register index width
    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    // major opcodes of the formats this core executes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

    // addi x0, x0, 0 fills every empty pipeline slot
    localparam logic [31:0] NOP_WORD = 32'h0000_0013;

    // register block offsets on the APB bus
    localparam logic [3:0] REG_CTRL    = 4'h0;
    localparam logic [3:0] REG_BOOT    = 4'h4;
    localparam logic [3:0] REG_STATUS  = 4'h8;
    localparam logic [3:0] REG_RETIRED = 4'hC;

    typedef struct packed {
        logic [6:0]        funct7;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]       imm12;
        logic [REG_AW-1:0] rs1;
        logic [2:0]        funct3;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]       imm20;
        logic [REG_AW-1:0] rd;
        logic [6:0]        opcode;
    } u_fmt_t;

    // one instruction word, seen through whichever format its opcode selects
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
    } instr_t;

    // encodings follow funct3 so the decoder can pass it straight through
    typedef enum logic [2:0] {
        ALU_ADD  = 3'd0,
        ALU_SLL  = 3'd1,
        ALU_SLT  = 3'd2,
        ALU_SLTU = 3'd3,
        ALU_XOR  = 3'd4,
        ALU_SRL  = 3'd5,
        ALU_OR   = 3'd6,
        ALU_AND  = 3'd7
    } alu_op_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    alu_sub;
        logic    alu_arith;
        logic    op2_imm;
        logic    rd_from_imm;
        logic    legal;
        logic    ebreak;
    } ctrl_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        instr_t          inst;
    } fetch_t;

    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        instr_t            inst;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [XLEN-1:0]   imm;
        ctrl_t             ctrl;
    } decode_t;

    // the execute register doubles as the retire record and the writeback stage
    typedef struct packed {
        logic              valid;
        logic [XLEN-1:0]   pc;
        instr_t            inst;
        logic [REG_AW-1:0] rs1;
        logic [REG_AW-1:0] rs2;
        logic [XLEN-1:0]   rs1_data;
        logic [XLEN-1:0]   rs2_data;
        logic [REG_AW-1:0] rd;
        logic [XLEN-1:0]   rd_data;
        logic              trap;
        logic              halt;
    } retire_t;

    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [3:0]  paddr;
        logic [31:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;
        logic        pslverr;
    } apb_rsp_t;

endpackage

`default_nettype wire

//--- core_regs.sv
`timescale 1ns/100ps
`default_nettype none

module core_regs #(
    parameter logic [core_pkg::XLEN-1:0] BOOT_RESET = '0
) (
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  core_pkg::apb_req_t          i_apb,
    output core_pkg::apb_rsp_t          o_apb,
    input  wire                         i_halted,
    input  wire                         i_retired,
    output logic                        o_run,
    output logic [core_pkg::XLEN-1:0]   o_boot_addr
);

    logic        access;
    logic        mapped;
    logic        read_only;
    logic [31:0] retired_cnt;

    // the access phase is the only cycle in which a transfer acts
    assign access = i_apb.psel && i_apb.penable;

    // status and retired count can be read but never written
    assign mapped    = i_apb.paddr[1:0] == 2'b00;
    assign read_only = i_apb.paddr == core_pkg::REG_STATUS ||
                       i_apb.paddr == core_pkg::REG_RETIRED;

    // the slave never inserts wait states
    assign o_apb.pready  = 1'b1;
    assign o_apb.pslverr = access && (!mapped || (i_apb.pwrite && read_only));

    // read data is muxed straight from the registers during the access cycle
    always_comb begin
        case (i_apb.paddr)
            core_pkg::REG_CTRL:    o_apb.prdata = {31'd0, o_run};
            core_pkg::REG_BOOT:    o_apb.prdata = o_boot_addr;
            core_pkg::REG_STATUS:  o_apb.prdata = {31'd0, i_halted};
            core_pkg::REG_RETIRED: o_apb.prdata = retired_cnt;
            default:               o_apb.prdata = '0;
        endcase
    end

    // writes land at the end of the access cycle, an erroring write changes nothing
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_run       <= 1'b0;
            o_boot_addr <= BOOT_RESET;
        end else if (access && i_apb.pwrite) begin
            if (i_apb.paddr == core_pkg::REG_CTRL)
                o_run <= i_apb.pwdata[0];
            // instructions are word aligned so the two low bits are dropped
            if (i_apb.paddr == core_pkg::REG_BOOT)
                o_boot_addr <= {i_apb.pwdata[31:2], 2'b00};
        end
    end

    // one pulse per retired instruction
    always_ff @(posedge i_clk) begin
        if (i_rst)
            retired_cnt <= '0;
        else if (i_retired)
            retired_cnt <= retired_cnt + 32'd1;
    end

endmodule

`default_nettype wire

//--- core_top.sv
`timescale 1ns/100ps
`default_nettype none

module core_top #(
    parameter logic [core_pkg::XLEN-1:0] BOOT_RESET = '0
) (
    input  wire                          i_clk,
    input  wire                          i_rst,
    output logic [core_pkg::XLEN-1:0]    o_imem_raddr,
    input  wire  [31:0]                  i_imem_rdata,
    input  core_pkg::apb_req_t           i_apb,
    output core_pkg::apb_rsp_t           o_apb,
    output core_pkg::retire_t            o_retire
);

    logic                        run;
    logic [core_pkg::XLEN-1:0]   boot_addr;
    logic                        halted;
    core_pkg::fetch_t            fetch_q;
    core_pkg::decode_t           dec_q;
    logic [core_pkg::REG_AW-1:0] rs1;
    logic [core_pkg::REG_AW-1:0] rs2;
    logic [core_pkg::REG_AW-1:0] rd;
    logic [core_pkg::XLEN-1:0]   rs1_data;
    logic [core_pkg::XLEN-1:0]   rs2_data;
    logic [core_pkg::XLEN-1:0]   imm;
    core_pkg::ctrl_t             ctrl;

    core_regs #(
        .BOOT_RESET (BOOT_RESET)
    ) core_regs_i (
        .i_clk       (i_clk),
        .i_rst       (i_rst),
        .i_apb       (i_apb),
        .o_apb       (o_apb),
        .i_halted    (halted),
        .i_retired   (o_retire.valid),
        .o_run       (run),
        .o_boot_addr (boot_addr)
    );

    fetch_stage fetch_stage_i (
        .i_clk        (i_clk),
        .i_rst        (i_rst),
        .i_run        (run),
        .i_boot_addr  (boot_addr),
        .i_halted     (halted),
        .o_imem_raddr (o_imem_raddr),
        .i_imem_rdata (i_imem_rdata),
        .o_fetch      (fetch_q)
    );

    decoder decoder_i (
        .i_inst (fetch_q.inst),
        .o_rs1  (rs1),
        .o_rs2  (rs2),
        .o_rd   (rd),
        .o_imm  (imm),
        .o_ctrl (ctrl)
    );

    // the writeback port is fed by the retire record itself
    regfile regfile_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_rs1      (rs1),
        .i_rs2      (rs2),
        .o_rs1_data (rs1_data),
        .o_rs2_data (rs2_data),
        .i_rd       (o_retire.rd),
        .i_rd_data  (o_retire.rd_data)
    );

    // decode pipeline register, nothing new enters once the core has halted
    always_ff @(posedge i_clk) begin
        dec_q.pc       <= fetch_q.pc;
        dec_q.inst     <= fetch_q.inst;
        dec_q.rs1      <= rs1;
        dec_q.rs2      <= rs2;
        dec_q.rd       <= rd;
        dec_q.rs1_data <= rs1_data;
        dec_q.rs2_data <= rs2_data;
        dec_q.imm      <= imm;
        dec_q.ctrl     <= ctrl;
        if (i_rst)
            dec_q.valid <= 1'b0;
        else
            dec_q.valid <= fetch_q.valid && !halted;
    end

    execute_stage execute_stage_i (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_dec    (dec_q),
        .o_retire (o_retire)
    );

    // sticky halt, only a reset brings the core back
    always_ff @(posedge i_clk) begin
        if (i_rst)
            halted <= 1'b0;
        else if (o_retire.valid && o_retire.halt)
            halted <= 1'b1;
    end

endmodule

`default_nettype wire

//--- decoder.sv
`timescale 1ns/100ps
`default_nettype none

module decoder (
    input  core_pkg::instr_t                 i_inst,
    output logic [core_pkg::REG_AW-1:0]      o_rs1,
    output logic [core_pkg::REG_AW-1:0]      o_rs2,
    output logic [core_pkg::REG_AW-1:0]      o_rd,
    output logic [core_pkg::XLEN-1:0]        o_imm,
    output core_pkg::ctrl_t                  o_ctrl
);

    always_comb begin
        // register fields a format lacks read as x0 so forwarding ignores them
        o_rs1  = '0;
        o_rs2  = '0;
        o_rd   = '0;
        o_imm  = '0;
        o_ctrl = '0;
        // the opcode field sits in the same place in every view
        o_ctrl.alu_op = core_pkg::alu_op_e'(i_inst.r.funct3);

        case (i_inst.r.opcode)
            core_pkg::OPC_OP: begin
                o_rs1 = i_inst.r.rs1;
                o_rs2 = i_inst.r.rs2;
                o_rd  = i_inst.r.rd;
                // funct7 bit 5 picks sub over add and sra over srl, nothing else
                o_ctrl.alu_sub   = i_inst.r.funct7[5] && i_inst.r.funct3 == 3'd0;
                o_ctrl.alu_arith = i_inst.r.funct7[5] && i_inst.r.funct3 == 3'd5;
                o_ctrl.legal     = i_inst.r.funct7 == 7'h00 ||
                                   (i_inst.r.funct7 == 7'h20 &&
                                    (i_inst.r.funct3 == 3'd0 || i_inst.r.funct3 == 3'd5));
            end
            core_pkg::OPC_OP_IMM: begin
                o_rs1 = i_inst.i.rs1;
                o_rd  = i_inst.i.rd;
                o_imm = {{20{i_inst.i.imm12[11]}}, i_inst.i.imm12};
                o_ctrl.op2_imm = 1'b1;
                // shifts carry a 5-bit amount, the upper seven bits act like funct7
                o_ctrl.alu_arith = i_inst.i.funct3 == 3'd5 && i_inst.i.imm12[10];
                case (i_inst.i.funct3)
                    3'd1:    o_ctrl.legal = i_inst.i.imm12[11:5] == 7'h00;
                    3'd5:    o_ctrl.legal = i_inst.i.imm12[11:5] == 7'h00 ||
                                            i_inst.i.imm12[11:5] == 7'h20;
                    default: o_ctrl.legal = 1'b1;
                endcase
            end
            core_pkg::OPC_LUI: begin
                o_rd  = i_inst.u.rd;
                o_imm = {i_inst.u.imm20, 12'd0};
                o_ctrl.rd_from_imm = 1'b1;
                o_ctrl.legal       = 1'b1;
            end
            core_pkg::OPC_SYSTEM: begin
                // ebreak is the only system instruction accepted
                o_ctrl.ebreak = i_inst.i.imm12 == 12'd1 && i_inst.i.rs1 == '0 &&
                                i_inst.i.funct3 == 3'd0 && i_inst.i.rd == '0;
                o_ctrl.legal  = o_ctrl.ebreak;
            end
            default: begin
                // unknown opcode, legal stays low and the word traps
                o_ctrl.legal = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- execute_stage.sv
`timescale 1ns/100ps
`default_nettype none

module execute_stage (
    input  wire                 i_clk,
    input  wire                 i_rst,
    input  core_pkg::decode_t   i_dec,
    output core_pkg::retire_t   o_retire
);

    logic [core_pkg::XLEN-1:0] rs1_fwd;
    logic [core_pkg::XLEN-1:0] rs2_fwd;
    logic [core_pkg::XLEN-1:0] op2;
    logic [core_pkg::XLEN-1:0] alu_result;
    logic [4:0]                shamt;
    logic                      halt_seen;
    logic                      squash;
    logic                      trap;
    core_pkg::retire_t         retire_d;

    // the record in the register is the next older instruction, whose result
    // has not reached the register file yet
    always_comb begin
        rs1_fwd = i_dec.rs1_data;
        rs2_fwd = i_dec.rs2_data;
        if (o_retire.valid && o_retire.rd != '0 && o_retire.rd == i_dec.rs1)
            rs1_fwd = o_retire.rd_data;
        if (o_retire.valid && o_retire.rd != '0 && o_retire.rd == i_dec.rs2)
            rs2_fwd = o_retire.rd_data;
    end

    assign op2   = i_dec.ctrl.op2_imm ? i_dec.imm : rs2_fwd;
    assign shamt = op2[4:0];

    always_comb begin
        case (i_dec.ctrl.alu_op)
            core_pkg::ALU_ADD:  alu_result = i_dec.ctrl.alu_sub ? rs1_fwd - op2 : rs1_fwd + op2;
            core_pkg::ALU_SLL:  alu_result = rs1_fwd << shamt;
            core_pkg::ALU_SLT:  alu_result = {31'd0, $signed(rs1_fwd) < $signed(op2)};
            core_pkg::ALU_SLTU: alu_result = {31'd0, rs1_fwd < op2};
            core_pkg::ALU_XOR:  alu_result = rs1_fwd ^ op2;
            core_pkg::ALU_SRL:  alu_result = i_dec.ctrl.alu_arith ?
                                             $unsigned($signed(rs1_fwd) >>> shamt) :
                                             rs1_fwd >> shamt;
            core_pkg::ALU_OR:   alu_result = rs1_fwd | op2;
            default:            alu_result = rs1_fwd & op2;
        endcase
    end

    // a halting record in the register kills whatever follows it, and the
    // sticky flag keeps doing so after that record has left
    assign squash = halt_seen || (o_retire.valid && o_retire.halt);
    assign trap   = !i_dec.ctrl.legal;

    always_comb begin
        retire_d.valid    = i_dec.valid && !squash;
        retire_d.pc       = i_dec.pc;
        retire_d.inst     = i_dec.inst;
        retire_d.rs1      = i_dec.rs1;
        retire_d.rs2      = i_dec.rs2;
        retire_d.rs1_data = rs1_fwd;
        retire_d.rs2_data = rs2_fwd;
        // traps and empty slots never write back
        retire_d.rd       = (retire_d.valid && !trap) ? i_dec.rd : '0;
        retire_d.rd_data  = i_dec.ctrl.rd_from_imm ? i_dec.imm : alu_result;
        retire_d.trap     = trap;
        retire_d.halt     = trap || i_dec.ctrl.ebreak;
    end

    always_ff @(posedge i_clk) begin
        o_retire <= retire_d;
        if (i_rst) begin
            o_retire.valid <= 1'b0;
            o_retire.rd    <= '0;
            o_retire.halt  <= 1'b0;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_rst)
            halt_seen <= 1'b0;
        else if (o_retire.valid && o_retire.halt)
            halt_seen <= 1'b1;
    end

endmodule

`default_nettype wire

//--- fetch_stage.sv
`timescale 1ns/100ps
`default_nettype none

module fetch_stage (
    input  wire                         i_clk,
    input  wire                         i_rst,
    input  wire                         i_run,
    input  wire  [core_pkg::XLEN-1:0]   i_boot_addr,
    input  wire                         i_halted,
    output logic [core_pkg::XLEN-1:0]   o_imem_raddr,
    input  wire  [31:0]                 i_imem_rdata,
    output core_pkg::fetch_t            o_fetch
);

    logic [core_pkg::XLEN-1:0] pc;
    logic [core_pkg::XLEN-1:0] next_pc;
    logic                      imem_valid;
    logic                      advance;

    // the word on the memory port belongs to the pc register, except in the
    // first cycle after reset when no address has been presented yet
    always_ff @(posedge i_clk) begin
        if (i_rst)
            imem_valid <= 1'b0;
        else
            imem_valid <= 1'b1;
    end

    // a fetch happens only while running, not halted and with a valid word
    assign advance = i_run && !i_halted && imem_valid;

    // while stopped the pc tracks the boot address, so the first fetch after
    // run goes high reads the boot word
    always_comb begin
        if (!i_run)
            next_pc = i_boot_addr;
        else if (advance)
            next_pc = pc + 32'd4;
        else
            next_pc = pc;
    end

    // the memory sees next_pc now and answers for it after the clock edge
    assign o_imem_raddr = next_pc;

    always_ff @(posedge i_clk) begin
        if (i_rst)
            pc <= '0;
        else
            pc <= next_pc;
    end

    // a stalled cycle hands decode an invalid nop instead of a stale word
    always_ff @(posedge i_clk) begin
        o_fetch.pc   <= pc;
        o_fetch.inst <= advance ? i_imem_rdata : core_pkg::NOP_WORD;
        if (i_rst)
            o_fetch.valid <= 1'b0;
        else
            o_fetch.valid <= advance;
    end

endmodule

`default_nettype wire

//--- regfile.sv
`timescale 1ns/100ps
`default_nettype none

module regfile (
    input  wire                          i_clk,
    input  wire                          i_rst,
    input  wire  [core_pkg::REG_AW-1:0]  i_rs1,
    input  wire  [core_pkg::REG_AW-1:0]  i_rs2,
    output logic [core_pkg::XLEN-1:0]    o_rs1_data,
    output logic [core_pkg::XLEN-1:0]    o_rs2_data,
    input  wire  [core_pkg::REG_AW-1:0]  i_rd,
    input  wire  [core_pkg::XLEN-1:0]    i_rd_data
);

    // x0 has no storage
    logic [core_pkg::XLEN-1:0] regs [1:31];
    logic                      wen;

    // writebacks to x0 and anything presented during reset are dropped
    assign wen = !i_rst && i_rd != '0;

    always_ff @(posedge i_clk) begin
        if (wen)
            regs[i_rd] <= i_rd_data;
    end

    // a read of the register written this cycle sees the new value, which is
    // what gives the writeback to execute forwarding path
    always_comb begin
        if (i_rs1 == '0)
            o_rs1_data = '0;
        else if (wen && i_rs1 == i_rd)
            o_rs1_data = i_rd_data;
        else
            o_rs1_data = regs[i_rs1];

        if (i_rs2 == '0)
            o_rs2_data = '0;
        else if (wen && i_rs2 == i_rd)
            o_rs2_data = i_rd_data;
        else
            o_rs2_data = regs[i_rs2];
    end

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
# builds the core testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_core -f all.f -o tb_core_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_core_sim > "$log" 2>&1
sim_status=$?
cat "$log"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

# the testbench prints the failure line on any failed check or timeout
if grep -q "Test failures found" "$log"; then
    echo "simulation reported failures"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

//--- tb_core.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core;

    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 5;
    localparam int MEM_WORDS    = 512;

    // layout of the golden image in word indices
    localparam int HDR_BASE   = 'h040;
    localparam int STEP_BASE  = 'h048;
    localparam int STEP_WORDS = 5;
    localparam int REC_BASE   = 'h100;
    localparam int REC_WORDS  = 8;

    // scenario step kinds as coded in the golden file
    localparam logic [31:0] STEP_WRITE = 32'd0;
    localparam logic [31:0] STEP_READ  = 32'd1;
    localparam logic [31:0] STEP_COUNT = 32'd2;
    localparam logic [31:0] STEP_HALT  = 32'd3;
    localparam logic [31:0] STEP_RESET = 32'd4;

    logic               clk;
    logic               rst;
    logic [31:0]        imem_raddr;
    logic [31:0]        imem_addr_q = '0;
    logic [31:0]        imem_rdata;
    core_pkg::apb_req_t apb_req;
    core_pkg::apb_rsp_t apb_rsp;
    core_pkg::retire_t  retire;

    logic [31:0] golden [0:MEM_WORDS-1];
    int          errors;
    int          rec_idx;
    int          seen_count;
    int          n_steps;
    int          n_recs;
    int          n_prog;
    logic        halt_flag;

    core_top #(
        .BOOT_RESET (32'h0000_0000)
    ) core_top_i (
        .i_clk        (clk),
        .i_rst        (rst),
        .o_imem_raddr (imem_raddr),
        .i_imem_rdata (imem_rdata),
        .i_apb        (apb_req),
        .o_apb        (apb_rsp),
        .o_retire     (retire)
    );

    // the low 64 words of the image double as the instruction memory
    // the address is taken at the clock edge and the word for it is
    // presented combinationally during the following cycle
    always @(posedge clk)
        imem_addr_q <= imem_raddr;

    assign imem_rdata = golden[imem_addr_q[7:2]];

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    task automatic compare_word(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp)
        else begin
            $display("Error: t=%0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    function automatic string step_name(input logic [31:0] kind);
        case (kind)
            STEP_WRITE: return "apb write";
            STEP_READ:  return "apb read";
            STEP_COUNT: return "retired count read";
            STEP_HALT:  return "program run to halt";
            STEP_RESET: return "reset";
            default:    return "unknown step";
        endcase
    endfunction

    // source register numbers by RV32I format, zero where the format has no such field
    function automatic logic [31:0] source_reg(input logic [31:0] inst, input bit second);
        case (inst[6:0])
            core_pkg::OPC_OP:     return second ? 32'(inst[24:20]) : 32'(inst[19:15]);
            core_pkg::OPC_OP_IMM: return second ? 32'd0 : 32'(inst[19:15]);
            default:              return 32'd0;
        endcase
    endfunction

    // one APB transfer with its setup and access cycles and then a random idle gap
    task automatic apb_transfer(input logic write, input logic [3:0] addr,
                                input logic [31:0] wdata, output logic [31:0] rdata,
                                output logic err);
        int gap;
        @(posedge clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        // response is combinational, so mid-cycle it is settled
        @(negedge clk);
        while (!apb_rsp.pready) @(negedge clk);
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        apb_req <= '0;
        gap = int'($urandom_range(2, 0));
        repeat (gap) @(posedge clk);
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        rst     <= 1'b1;
        apb_req <= '0;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic check_record(input int idx);
        int base;
        base = REC_BASE + idx * REC_WORDS;
        compare_word("o_retire.pc", retire.pc, golden[base]);
        compare_word("o_retire.inst", retire.inst, golden[base + 1]);
        compare_word("o_retire.rs1", 32'(retire.rs1), source_reg(golden[base + 1], 1'b0));
        compare_word("o_retire.rs2", 32'(retire.rs2), source_reg(golden[base + 1], 1'b1));
        compare_word("o_retire.rd", 32'(retire.rd), golden[base + 2]);
        // a halting instruction produces no result to compare
        if (golden[base + 7] == 32'd0)
            compare_word("o_retire.rd_data", retire.rd_data, golden[base + 3]);
        compare_word("o_retire.rs1_data", retire.rs1_data, golden[base + 4]);
        compare_word("o_retire.rs2_data", retire.rs2_data, golden[base + 5]);
        compare_word("o_retire.trap", 32'(retire.trap), golden[base + 6]);
        compare_word("o_retire.halt", 32'(retire.halt), golden[base + 7]);
    endtask

    // waits for the halting record and then lets the pipe drain to catch stragglers
    task automatic wait_for_halt(input int expected_total);
        while (!halt_flag) @(posedge clk);
        repeat (4) @(posedge clk);
        assert (rec_idx == expected_total)
        else begin
            $display("%0t: %0d retire records seen so far but %0d were expected",
                     $time, rec_idx, expected_total);
            errors++;
        end
    endtask

    // retire records are registered, so they are stable at mid-cycle
    always @(negedge clk) begin
        if (rst) begin
            seen_count = 0;
            halt_flag  = 1'b0;
        end else if (retire.valid) begin
            seen_count++;
            assert (rec_idx < n_recs && !halt_flag)
            else begin
                $display("%0t: unexpected retire record for pc %h", $time, retire.pc);
                errors++;
            end
            if (rec_idx < n_recs) begin
                check_record(rec_idx);
                rec_idx++;
            end
            if (retire.halt)
                halt_flag = 1'b1;
        end
    end

    initial begin
        int          base;
        int          errors_before;
        int          tests_failed;
        logic [31:0] op;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] exp_rdata;
        logic [31:0] exp_err;
        logic [31:0] rdata;
        logic        err;

        void'($urandom(96505));
        rst          = 1'b1;
        apb_req      = '0;
        errors       = 0;
        rec_idx      = 0;
        seen_count   = 0;
        halt_flag    = 1'b0;
        tests_failed = 0;

        // unlisted words hold an illegal opcode tagged with their own index
        for (int a = 0; a < MEM_WORDS; a++)
            golden[a] = {a[8:0], 23'h00_007f};
        $readmemh("core_golden.txt", golden);
        n_steps = int'(golden[HDR_BASE]);
        n_recs  = int'(golden[HDR_BASE + 1]);
        n_prog  = int'(golden[HDR_BASE + 2]);

        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        for (int s = 0; s < n_steps; s++) begin
            base          = STEP_BASE + s * STEP_WORDS;
            op            = golden[base];
            addr          = golden[base + 1];
            wdata         = golden[base + 2];
            exp_rdata     = golden[base + 3];
            exp_err       = golden[base + 4];
            errors_before = errors;
            case (op)
                STEP_WRITE, STEP_READ, STEP_COUNT: begin
                    apb_transfer(op == STEP_WRITE, addr[3:0], wdata, rdata, err);
                    compare_word("o_apb.pslverr", 32'(err), exp_err);
                    if (op == STEP_READ)
                        compare_word("o_apb.prdata", rdata, exp_rdata);
                    // the count must match what the monitor saw retire
                    if (op == STEP_COUNT)
                        compare_word("o_apb.prdata", rdata, 32'(seen_count));
                end
                STEP_HALT:  wait_for_halt(int'(wdata));
                STEP_RESET: pulse_reset();
                default: begin
                    assert (0)
                    else begin
                        $display("step %0d has an unknown kind %h", s, op);
                        errors++;
                    end
                end
            endcase
            if (errors == errors_before) begin
                $display("test %0d (%s, offset %h) passed", s, step_name(op), addr[3:0]);
            end else begin
                $display("test %0d (%s, offset %h) FAILED", s, step_name(op), addr[3:0]);
                tests_failed++;
            end
        end

        $display("tests run %0d, passed %0d, failed %0d, failed checks %0d",
                 n_steps, n_steps - tests_failed, tests_failed, errors);
        if (errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

    // budget of a few cycles per step plus the program and the pipeline fill
    initial begin
        longint limit_cycles;
        #1;
        limit_cycles = longint'(n_prog + 6 * n_steps + 50);
        #(limit_cycles * CLK_PERIOD);
        $display("watchdog expired after %0d cycles before the scenario finished",
                 limit_cycles);
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb_core_assert.sv
`timescale 1ns/100ps
`default_nettype none

module tb_core_assert #(
    // set on the pipeline instance, clear on the register block instance
    parameter bit PIPE_SIDE = 1'b0
) (
    input wire        i_clk,
    input wire        i_rst,
    input wire        i_halted,
    input wire        i_retire_valid,
    input wire        i_trap,
    input wire [4:0]  i_rd,
    input wire        i_pready,
    input wire [31:0] i_count
);

    // once halted nothing else may retire
    no_retire_when_halted: assert property (
        @(posedge i_clk) disable iff (i_rst) i_halted |-> !i_retire_valid
    ) else $error("retire record presented while the core is halted");

    if (PIPE_SIDE) begin : g_pipe
        // a trapping instruction must not write back
        trap_has_no_rd: assert property (
            @(posedge i_clk) disable iff (i_rst) i_trap |-> i_rd == 5'd0
        ) else $error("trap record carries a nonzero destination register");
    end else begin : g_regs
        // the register block never stretches a transfer
        pready_high: assert property (
            @(posedge i_clk) i_pready
        ) else $error("pready dropped low");

        // at most one instruction retires per clock
        count_step: assert property (
            @(posedge i_clk) disable iff (i_rst) (i_count - $past(i_count)) <= 32'd1
        ) else $error("retired count advanced by more than one");
    end

endmodule

// the pipeline instance watches the retire register
bind execute_stage tb_core_assert #(
    .PIPE_SIDE (1'b1)
) exec_assert_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_halted       (halt_seen),
    .i_retire_valid (o_retire.valid),
    .i_trap         (o_retire.trap),
    .i_rd           (o_retire.rd),
    .i_pready       (1'b1),
    .i_count        (32'd0)
);

// the register block instance watches APB and the retired counter
bind core_regs tb_core_assert #(
    .PIPE_SIDE (1'b0)
) regs_assert_i (
    .i_clk          (i_clk),
    .i_rst          (i_rst),
    .i_halted       (i_halted),
    .i_retire_valid (i_retired),
    .i_trap         (1'b0),
    .i_rd           (5'd0),
    .i_pready       (o_apb.pready),
    .i_count        (retired_cnt)
);

`default_nettype wire
